/* all.f */
verilog/fg_command_pkg.sv
verilog/fg_channel_pkg.sv
verilog/waveform_ram.sv
verilog/host_command_decoder.sv
verilog/function_generator.sv
verilog/waveform_generator_top.sv
verif/waveform_generator_properties.sv
verif/waveform_generator_tb.sv

/* verif/waveform_generator_tb.sv */
`default_nettype none

module waveform_generator_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import fg_command_pkg::*;
	import fg_channel_pkg::*;

	localparam int DATA_BUS_WIDTH = 8;
	// small memories so loops wrap often
	localparam int ADDRESS_BUS_DEPTH = 5;
	localparam int NUMBER_OF_CHANNELS = 4;
	localparam int CHANNEL_BITS = $clog2(NUMBER_OF_CHANNELS);
	localparam int DEPTH = 1 << ADDRESS_BUS_DEPTH;
	// cycles allowed for a channel to start
	localparam int START_LIMIT = 8;

	logic clock = 1'b0;
	logic reset;
	logic cmd_valid;
	fg_opcode_t cmd_opcode;
	logic [CHANNEL_BITS-1:0] cmd_channel;
	logic [ADDRESS_BUS_DEPTH-1:0] cmd_address;
	logic [DATA_BUS_WIDTH-1:0] cmd_data;
	wire [NUMBER_OF_CHANNELS*DATA_BUS_WIDTH-1:0] samples;
	wire [NUMBER_OF_CHANNELS-1:0] sample_valid;

	// cycle model of memories, controls and playback
	logic [DATA_BUS_WIDTH-1:0] model_mem [NUMBER_OF_CHANNELS][DEPTH];
	logic [DATA_BUS_WIDTH-1:0] model_ram_out [NUMBER_OF_CHANNELS];
	logic [ADDRESS_BUS_DEPTH-1:0] model_read_address [NUMBER_OF_CHANNELS];
	logic [ADDRESS_BUS_DEPTH-1:0] model_last [NUMBER_OF_CHANNELS];
	logic model_enable [NUMBER_OF_CHANNELS];
	fg_play_state_t model_state [NUMBER_OF_CHANNELS];

	int seed = 32'h0b4d04fa;
	int mismatch_count = 0;
	int timeout_count = 0;

	waveform_generator_top #(
		.DATA_BUS_WIDTH(DATA_BUS_WIDTH),
		.ADDRESS_BUS_DEPTH(ADDRESS_BUS_DEPTH),
		.NUMBER_OF_CHANNELS(NUMBER_OF_CHANNELS)
	) dut_i (
		.clock(clock),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_opcode(cmd_opcode),
		.cmd_channel(cmd_channel),
		.cmd_address(cmd_address),
		.cmd_data(cmd_data),
		.samples(samples),
		.sample_valid(sample_valid)
	);

	// 20 ns period
	always #10 clock = ~clock;

	// model steps on the same edge as the DUT
	// reads use the memory before this edge's write
	always @(posedge clock) begin : cycle_model
		int ch;
		for (ch = 0; ch < NUMBER_OF_CHANNELS; ch++) begin
			model_ram_out[ch] = model_mem[ch][model_read_address[ch]];
			if (reset || !model_enable[ch]) begin
				model_state[ch] = PLAY_IDLE;
				model_read_address[ch] = '0;
			end else begin
				model_state[ch] = PLAY_RUNNING;
				if (model_read_address[ch] == model_last[ch])
					model_read_address[ch] = '0;
				else
					model_read_address[ch] = model_read_address[ch] + 1'b1;
			end
		end
		// write strobe is not held off by reset
		if (cmd_valid && cmd_opcode == OP_WRITE_SAMPLE)
			model_mem[cmd_channel][cmd_address] = cmd_data;
		if (reset) begin
			for (ch = 0; ch < NUMBER_OF_CHANNELS; ch++) begin
				model_enable[ch] = 1'b0;
				model_last[ch] = '1;
			end
		end else if (cmd_valid) begin
			case (cmd_opcode)
				OP_SET_LAST_ADDRESS: model_last[cmd_channel] = cmd_address;
				OP_ENABLE: model_enable[cmd_channel] = 1'b1;
				OP_DISABLE: model_enable[cmd_channel] = 1'b0;
				default: ;
			endcase
		end
	end

	task automatic compare_sample(input int ch, input logic [DATA_BUS_WIDTH-1:0] expected,
			input logic [DATA_BUS_WIDTH-1:0] actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t: samples[%0d] expected %h actual %h",
				$time, ch, expected, actual);
		end
	endtask

	task automatic compare_valid(input int ch, input logic expected, input logic actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t: sample_valid[%0d] expected %b actual %b",
				$time, ch, expected, actual);
		end
	endtask

	// every output against the model at each falling edge
	always @(negedge clock) begin : output_check
		int ch;
		logic [DATA_BUS_WIDTH-1:0] expected;
		for (ch = 0; ch < NUMBER_OF_CHANNELS; ch++) begin
			expected = (model_state[ch] == PLAY_RUNNING) ? model_ram_out[ch] : '0;
			compare_valid(ch, model_state[ch] == PLAY_RUNNING, sample_valid[ch]);
			compare_sample(ch, expected, samples[ch*DATA_BUS_WIDTH +: DATA_BUS_WIDTH]);
		end
	end

	// word stored at each address, unique per channel and address
	function automatic logic [DATA_BUS_WIDTH-1:0] fill_word(input int ch, input int address);
		return DATA_BUS_WIDTH'(ch * 64 + address);
	endfunction

	// drive one command for the next rising edge
	task automatic send_command(input fg_opcode_t opcode, input int ch,
			input logic [ADDRESS_BUS_DEPTH-1:0] address,
			input logic [DATA_BUS_WIDTH-1:0] data);
		@(negedge clock);
		cmd_valid = 1'b1;
		cmd_opcode = opcode;
		cmd_channel = CHANNEL_BITS'(ch);
		cmd_address = address;
		cmd_data = data;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(negedge clock);
			cmd_valid = 1'b0;
		end
	endtask

	// returns at the falling edge where the channel first shows valid
	task automatic wait_for_valid(input int ch, output int cycles);
		bit seen;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < START_LIMIT) begin
			@(negedge clock);
			cmd_valid = 1'b0;
			cycles++;
			seen = sample_valid[ch];
		end
		if (!seen) begin
			timeout_count++;
			$display("Timeout at %0t: channel %0d never raised sample_valid", $time, ch);
		end
	endtask

	task automatic fill_channel(input int ch);
		int address;
		for (address = 0; address < DEPTH; address++)
			send_command(OP_WRITE_SAMPLE, ch, ADDRESS_BUS_DEPTH'(address),
				fill_word(ch, address));
	endtask

	initial begin : stimulus
		int ch;
		int i;
		int k;
		int cycles;
		int loop_last;
		logic [31:0] r;

		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_opcode = OP_WRITE_SAMPLE;
		cmd_channel = '0;
		cmd_address = '0;
		cmd_data = '0;
		repeat (4) @(negedge clock);
		reset = 1'b0;

		// reset state, all outputs quiet
		for (ch = 0; ch < NUMBER_OF_CHANNELS; ch++) begin
			compare_valid(ch, 1'b0, sample_valid[ch]);
			compare_sample(ch, '0, samples[ch*DATA_BUS_WIDTH +: DATA_BUS_WIDTH]);
		end

		// channel 0 gets a ramp, the rest a channel-tagged pattern
		for (ch = 0; ch < NUMBER_OF_CHANNELS; ch++)
			fill_channel(ch);
		idle_cycles(2);

		// ramp over the full memory, wraps at the top
		send_command(OP_ENABLE, 0, '0, '0);
		wait_for_valid(0, cycles);
		if (cycles != 2) begin
			mismatch_count++;
			$display("Mismatch at %0t: enable latency[0] expected 2 actual %0d", $time, cycles);
		end
		idle_cycles(2 * DEPTH + 5);

		// programmed loop on another channel
		r = $random(seed);
		ch = 1 + (r[7:0] % (NUMBER_OF_CHANNELS - 1));
		loop_last = r[15:8] % DEPTH;
		send_command(OP_SET_LAST_ADDRESS, ch, ADDRESS_BUS_DEPTH'(loop_last), '0);
		send_command(OP_ENABLE, ch, '0, '0);
		wait_for_valid(ch, cycles);
		for (k = 0; k < 2 * (loop_last + 1) + 3; k++) begin
			if (k > 0)
				idle_cycles(1);
			compare_sample(ch, fill_word(ch, k % (loop_last + 1)),
				samples[ch*DATA_BUS_WIDTH +: DATA_BUS_WIDTH]);
		end
		// shorten the loop mid-playback
		send_command(OP_SET_LAST_ADDRESS, ch, ADDRESS_BUS_DEPTH'(loop_last / 2), '0);
		idle_cycles(40);
		send_command(OP_DISABLE, ch, '0, '0);

		// disable zeroes the output, restart begins at address 0
		send_command(OP_DISABLE, 0, '0, '0);
		idle_cycles(3);
		send_command(OP_ENABLE, 0, '0, '0);
		wait_for_valid(0, cycles);
		compare_sample(0, fill_word(0, 0), samples[DATA_BUS_WIDTH-1:0]);
		// enable while running changes nothing
		send_command(OP_ENABLE, 0, '0, '0);
		idle_cycles(10);

		// seeded random mix, writes often hit the address being read
		for (i = 0; i < 800; i++) begin
			r = $random(seed);
			ch = r[5:4];
			if (r[3:0] < 6) begin
				send_command(OP_WRITE_SAMPLE, ch,
					r[6] ? model_read_address[ch] : r[8 +: ADDRESS_BUS_DEPTH], r[23:16]);
			end else if (r[3:0] < 8) begin
				send_command(OP_SET_LAST_ADDRESS, ch, r[8 +: ADDRESS_BUS_DEPTH], '0);
			end else if (r[3:0] < 11) begin
				send_command(OP_ENABLE, ch, '0, '0);
			end else if (r[3:0] < 12) begin
				send_command(OP_DISABLE, ch, '0, '0);
			end else begin
				idle_cycles(1);
			end
		end
		idle_cycles(5);

		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatch_count, timeout_count, dut_i.properties_i.failure_count);
		if (mismatch_count == 0 && timeout_count == 0
				&& dut_i.properties_i.failure_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/waveform_generator_properties.sv */
`default_nettype none

// output rules of the generator, checked on the top level ports
module waveform_generator_properties #(
	parameter int DATA_BUS_WIDTH = 8,
	parameter int NUMBER_OF_CHANNELS = 4
) (
	input wire clock,
	input wire reset,
	input wire cmd_valid,
	input wire fg_command_pkg::fg_opcode_t cmd_opcode,
	input wire [$clog2(NUMBER_OF_CHANNELS)-1:0] cmd_channel,
	input wire [NUMBER_OF_CHANNELS*DATA_BUS_WIDTH-1:0] samples,
	input wire [NUMBER_OF_CHANNELS-1:0] sample_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	import fg_command_pkg::*;

	// failed assertions so far, read by the testbench at the end
	int failure_count = 0;

	// all channels quiet the cycle after reset
	assert property (@(posedge clock) reset |=> sample_valid == '0)
		else begin
			$error("sample_valid high right after reset");
			failure_count++;
		end

	for (genvar ch = 0; ch < NUMBER_OF_CHANNELS; ch++) begin : chan
		// idle channel drives a zero word
		assert property (@(posedge clock) disable iff (reset)
			!sample_valid[ch] |-> samples[ch*DATA_BUS_WIDTH +: DATA_BUS_WIDTH] == '0)
			else begin
				$error("nonzero samples word on idle channel %0d", ch);
				failure_count++;
			end

		// start needs an enable for this channel two edges back
		assert property (@(posedge clock) disable iff (reset)
			$rose(sample_valid[ch]) |->
				$past(cmd_valid && cmd_opcode == OP_ENABLE && cmd_channel == ch, 2))
			else begin
				$error("channel %0d started without an enable command", ch);
				failure_count++;
			end
	end

endmodule

bind waveform_generator_top waveform_generator_properties #(
	.DATA_BUS_WIDTH(DATA_BUS_WIDTH),
	.NUMBER_OF_CHANNELS(NUMBER_OF_CHANNELS)
) properties_i (
	.clock(clock),
	.reset(reset),
	.cmd_valid(cmd_valid),
	.cmd_opcode(cmd_opcode),
	.cmd_channel(cmd_channel),
	.samples(samples),
	.sample_valid(sample_valid)
);

`default_nettype wire

/* verilog/waveform_generator_top.sv */
`default_nettype none

// arbitrary waveform generator subsystem
// host command port in, one parallel sample word per channel out
module waveform_generator_top #(
	// sample width, matches the serializer input
	parameter int DATA_BUS_WIDTH = 8,
	// log2 of words per channel memory
	parameter int ADDRESS_BUS_DEPTH = 11,
	// power of two so every channel index exists
	parameter int NUMBER_OF_CHANNELS = 4
) (
	input wire clock,
	input wire reset,
	input wire cmd_valid,
	input wire fg_command_pkg::fg_opcode_t cmd_opcode,
	input wire [$clog2(NUMBER_OF_CHANNELS)-1:0] cmd_channel,
	input wire [ADDRESS_BUS_DEPTH-1:0] cmd_address,
	input wire [DATA_BUS_WIDTH-1:0] cmd_data,
	output wire [NUMBER_OF_CHANNELS*DATA_BUS_WIDTH-1:0] samples,
	output wire [NUMBER_OF_CHANNELS-1:0] sample_valid
);

	// decoder to generator
	wire [NUMBER_OF_CHANNELS-1:0] write_enable;
	wire [ADDRESS_BUS_DEPTH-1:0] write_address;
	wire [DATA_BUS_WIDTH-1:0] write_data;
	wire [NUMBER_OF_CHANNELS-1:0] channel_enable;
	wire [NUMBER_OF_CHANNELS*ADDRESS_BUS_DEPTH-1:0] last_address;

	host_command_decoder #(
		.DATA_BUS_WIDTH(DATA_BUS_WIDTH),
		.ADDRESS_BUS_DEPTH(ADDRESS_BUS_DEPTH),
		.NUMBER_OF_CHANNELS(NUMBER_OF_CHANNELS)
	) decoder_i (
		.clock(clock),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_opcode(cmd_opcode),
		.cmd_channel(cmd_channel),
		.cmd_address(cmd_address),
		.cmd_data(cmd_data),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data),
		.channel_enable(channel_enable),
		.last_address(last_address)
	);

	function_generator #(
		.DATA_BUS_WIDTH(DATA_BUS_WIDTH),
		.ADDRESS_BUS_DEPTH(ADDRESS_BUS_DEPTH),
		.NUMBER_OF_CHANNELS(NUMBER_OF_CHANNELS)
	) generator_i (
		.clock(clock),
		.reset(reset),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data),
		.channel_enable(channel_enable),
		.last_address(last_address),
		.samples(samples),
		.sample_valid(sample_valid)
	);

endmodule

`default_nettype wire

/* verilog/function_generator.sv */
`default_nettype none

// multi-channel playback core
// each channel loops its own memory from 0 to its last address
module function_generator #(
	parameter int DATA_BUS_WIDTH = 8,
	parameter int ADDRESS_BUS_DEPTH = 11,
	parameter int NUMBER_OF_CHANNELS = 4
) (
	input wire clock,
	input wire reset,
	input wire [NUMBER_OF_CHANNELS-1:0] write_enable,
	input wire [ADDRESS_BUS_DEPTH-1:0] write_address,
	input wire [DATA_BUS_WIDTH-1:0] write_data,
	input wire [NUMBER_OF_CHANNELS-1:0] channel_enable,
	input wire [NUMBER_OF_CHANNELS*ADDRESS_BUS_DEPTH-1:0] last_address,
	output wire [NUMBER_OF_CHANNELS*DATA_BUS_WIDTH-1:0] samples,
	output wire [NUMBER_OF_CHANNELS-1:0] sample_valid
);

	import fg_channel_pkg::*;

	for (genvar ch = 0; ch < NUMBER_OF_CHANNELS; ch++) begin : chan
		// address the memory reads at the next edge
		logic [ADDRESS_BUS_DEPTH-1:0] read_address;
		// registered memory output
		logic [DATA_BUS_WIDTH-1:0] ram_data;
		// this channel's loop end
		logic [ADDRESS_BUS_DEPTH-1:0] channel_last;
		fg_play_state_t play_state;

		assign channel_last = last_address[ch*ADDRESS_BUS_DEPTH +: ADDRESS_BUS_DEPTH];

		waveform_ram #(
			.DATA_BUS_WIDTH(DATA_BUS_WIDTH),
			.ADDRESS_BUS_DEPTH(ADDRESS_BUS_DEPTH)
		) ram_i (
			.clock(clock),
			.write_enable(write_enable[ch]),
			.write_address(write_address),
			.data_in(write_data),
			.read_address(read_address),
			.data_out(ram_data)
		);

		// state follows the enable level one edge later
		// the edge that enters running also reads address 0,
		// so the first word shows right after that edge
		always_ff @(posedge clock) begin
			if (reset) begin
				play_state <= PLAY_IDLE;
				read_address <= '0;
			end else if (channel_enable[ch]) begin
				play_state <= PLAY_RUNNING;
				// loop end reached, restart at 0
				if (read_address == channel_last) begin
					read_address <= '0;
				end else begin
					// plain increment also wraps at the memory top
					read_address <= read_address + 1'b1;
				end
			end else begin
				play_state <= PLAY_IDLE;
				// parked so a restart begins at address 0
				read_address <= '0;
			end
		end

		// valid only while running
		assign sample_valid[ch] = (play_state == PLAY_RUNNING);
		// idle channels present a zero word
		assign samples[ch*DATA_BUS_WIDTH +: DATA_BUS_WIDTH] = sample_valid[ch] ? ram_data : '0;
	end

endmodule

`default_nettype wire

/* verilog/host_command_decoder.sv */
`default_nettype none

// turns host command strobes into per-channel controls
module host_command_decoder #(
	parameter int DATA_BUS_WIDTH = 8,
	parameter int ADDRESS_BUS_DEPTH = 11,
	parameter int NUMBER_OF_CHANNELS = 4
) (
	input wire clock,
	input wire reset,
	input wire cmd_valid,
	input wire fg_command_pkg::fg_opcode_t cmd_opcode,
	input wire [$clog2(NUMBER_OF_CHANNELS)-1:0] cmd_channel,
	input wire [ADDRESS_BUS_DEPTH-1:0] cmd_address,
	input wire [DATA_BUS_WIDTH-1:0] cmd_data,
	output logic [NUMBER_OF_CHANNELS-1:0] write_enable,
	output logic [ADDRESS_BUS_DEPTH-1:0] write_address,
	output logic [DATA_BUS_WIDTH-1:0] write_data,
	output logic [NUMBER_OF_CHANNELS-1:0] channel_enable,
	output logic [NUMBER_OF_CHANNELS*ADDRESS_BUS_DEPTH-1:0] last_address
);

	import fg_command_pkg::*;

	// one-hot of the addressed channel
	logic [NUMBER_OF_CHANNELS-1:0] channel_select;
	// decoded opcode strobes, only while cmd_valid
	logic write_command;
	logic last_command;
	logic enable_command;
	logic disable_command;

	always_comb begin
		channel_select = '0;
		channel_select[cmd_channel] = 1'b1;
	end

	// opcode decode
	always_comb begin
		write_command = 1'b0;
		last_command = 1'b0;
		enable_command = 1'b0;
		disable_command = 1'b0;
		if (cmd_valid) begin
			case (cmd_opcode)
				OP_WRITE_SAMPLE: write_command = 1'b1;
				OP_SET_LAST_ADDRESS: last_command = 1'b1;
				OP_ENABLE: enable_command = 1'b1;
				OP_DISABLE: disable_command = 1'b1;
				default: ;
			endcase
		end
	end

	// write strobe lands in the memory at the same edge
	assign write_enable = write_command ? channel_select : '0;
	// address and data go straight to every memory
	assign write_address = cmd_address;
	assign write_data = cmd_data;

	// enable levels and loop ends
	// after reset all channels off, loops span the whole memory
	always_ff @(posedge clock) begin
		if (reset) begin
			channel_enable <= '0;
			last_address <= '1;
		end else begin
			if (enable_command) begin
				channel_enable[cmd_channel] <= 1'b1;
			end else if (disable_command) begin
				channel_enable[cmd_channel] <= 1'b0;
			end
			if (last_command) begin
				last_address[cmd_channel*ADDRESS_BUS_DEPTH +: ADDRESS_BUS_DEPTH] <= cmd_address;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/waveform_ram.sv */
`default_nettype none

// sample memory for one channel
// write port from the host, read port from the playback counter
module waveform_ram #(
	parameter int DATA_BUS_WIDTH = 8,
	parameter int ADDRESS_BUS_DEPTH = 11
) (
	input wire clock,
	input wire write_enable,
	input wire [ADDRESS_BUS_DEPTH-1:0] write_address,
	input wire [DATA_BUS_WIDTH-1:0] data_in,
	input wire [ADDRESS_BUS_DEPTH-1:0] read_address,
	output logic [DATA_BUS_WIDTH-1:0] data_out
);

	// number of words
	localparam int DEPTH = 1 << ADDRESS_BUS_DEPTH;

	// contents are not cleared, host loads them before playback
	logic [DATA_BUS_WIDTH-1:0] memory [0:DEPTH-1];

	// both ports on the same clock
	// nonblocking read and write give read-first on a collision
	always_ff @(posedge clock) begin
		if (write_enable) begin
			memory[write_address] <= data_in;
		end
		// read port always enabled
		data_out <= memory[read_address];
	end

endmodule

`default_nettype wire

/* verilog/fg_channel_pkg.sv */
`default_nettype none

// playback state of a single generator channel
package fg_channel_pkg;

	// idle: output zero, read address parked at 0
	// running: one sample per clock, looping over the memory
	typedef enum logic {
		PLAY_IDLE    = 1'b0,
		PLAY_RUNNING = 1'b1
	} fg_play_state_t;

endpackage

`default_nettype wire

/* verilog/fg_command_pkg.sv */
`default_nettype none

// host command interface of the waveform generator
// one command per cycle while cmd_valid is high, no back-pressure
package fg_command_pkg;

	// width of the opcode field
	localparam int OPCODE_WIDTH = 2;

	// field use per opcode
	// cmd_channel selects the target channel for every opcode
	// cmd_address is the sample address for writes
	// cmd_address is the loop end for set last address
	// cmd_data only matters for sample writes
	typedef enum logic [OPCODE_WIDTH-1:0] {
		// store cmd_data at cmd_address of the channel memory
		OP_WRITE_SAMPLE     = 2'd0,
		// channel loops back to 0 after cmd_address
		OP_SET_LAST_ADDRESS = 2'd1,
		// start playback from address 0
		OP_ENABLE           = 2'd2,
		// stop playback and zero the output
		OP_DISABLE          = 2'd3
	} fg_opcode_t;

endpackage

`default_nettype wire
